/* hw/font5_pkg.sv */
package font5_pkg;

	////////////////////////////////////////////////////////////////////////////
	// ADC clock groups
	////////////////////////////////////////////////////////////////////////////

	localparam int n_groups = 3;          // adc1, adc2, adc3 clock groups

	typedef logic [1:0] group_t;          // Group index, 0 to 2 only
	typedef logic [n_groups-1:0] group_mask_t; // One bit per group

	////////////////////////////////////////////////////////////////////////////
	// Delay line
	////////////////////////////////////////////////////////////////////////////

	localparam int tap_w   = 6;           // 64 taps in the clock delay element
	localparam int max_tap = 63;          // Last usable tap

	typedef logic [tap_w-1:0] tap_t;

	// Wait after every clear or step before the DDR samples are trusted
	localparam int settle_cycles = 16;    // clk357 cycles
	localparam int settle_w      = 5;     // Must hold settle_cycles

	typedef logic [settle_w-1:0] settle_t;

	// Final position sits this far past the data-ready edge
	localparam int offset_taps = 8;

	////////////////////////////////////////////////////////////////////////////
	// Calibration sequencer
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		idle,                             // Waiting for a request
		clear,                            // Delay back to tap 0
		settle_ref,                       // Settle, then take tap-0 phase
		step,                             // One tap forward while searching
		settle_step,                      // Settle, then judge the phase
		trim,                             // Walk on towards the target tap
		settle_trim,                      // Settle after a trim step
		clear_fail,                       // No edge, park the delay at tap 0
		report                            // Result held until taken
	} cal_state_t;

endpackage

/* hw/settle_timer.sv */
`timescale 1ns/1ps

module settle_timer (
	input  logic clk357,
	input  logic rst_n,
	input  logic timer_start,             // Load and run
	output logic timer_done               // One cycle at count zero
);
	import font5_pkg::*;

	settle_t cnt;                         // Cycles left to wait
	logic    run;                         // Count in progress

	always_ff @(posedge clk357 or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
			run <= 1'b0;
		end else if (timer_start) begin
			cnt <= settle_t'(settle_cycles); // Restart wins over a running count
			run <= 1'b1;
		end else if (run) begin
			if (cnt == '0)
				run <= 1'b0;          // Done shown, stop
			else
				cnt <= cnt - settle_t'(1);
		end
	end

	// Single pulse since run drops on the next edge
	assign timer_done = run && (cnt == '0);

endmodule

/* hw/phase_monitor.sv */
`timescale 1ns/1ps

module phase_monitor (
	input  logic                   clk357,
	input  logic                   rst_n,
	input  font5_pkg::group_mask_t q1,  // Rising-edge samples
	input  font5_pkg::group_mask_t q2,  // Falling-edge samples
	input  font5_pkg::group_t      group_sel,
	input  logic                   capture_ref,
	input  logic                   sample_en,
	output logic                   phase_flip
);
	import font5_pkg::*;

	logic q1_r;                           // Selected group, rising sample
	logic q2_r;                           // Selected group, falling sample
	logic ref_phase;                      // q1 seen at tap 0

	always_ff @(posedge clk357 or negedge rst_n) begin
		if (!rst_n) begin
			q1_r      <= 1'b0;
			q2_r      <= 1'b0;
			ref_phase <= 1'b0;
		end else begin
			q1_r <= q1[group_sel];     // Retimed off the DDR flops
			q2_r <= q2[group_sel];
			if (capture_ref)
				ref_phase <= q1_r;
		end
	end

	// Flip needs both half-cycle samples moved, so a sample caught
	// right on the data-ready transition is not taken as the edge
	assign phase_flip = sample_en && (q1_r != ref_phase) && (q2_r == ref_phase);

	// Reference and judgement come from different settle waits
	a_ref_vs_sample: assert property (@(posedge clk357) disable iff (!rst_n)
		!(capture_ref && sample_en));

endmodule

/* hw/delay_tap_ctrl.sv */
`timescale 1ns/1ps

module delay_tap_ctrl (
	input  logic                   clk357,
	input  logic                   rst_n,
	input  font5_pkg::group_t      group_sel,
	input  logic                   clear_cmd,  // Delay back to tap 0
	input  logic                   step_cmd,   // One tap forward
	input  logic                   mark_edge,  // Current tap is the edge
	output font5_pkg::group_mask_t delay_rst,
	output font5_pkg::group_mask_t delay_ce,
	output font5_pkg::tap_t        cur_tap,
	output logic                   at_max,
	output logic                   at_target
);
	import font5_pkg::*;

	group_mask_t    sel_mask;             // One-hot of the selected group
	tap_t           tap_cnt;              // Mirror of the delay element
	tap_t           edge_tap;             // Tap where the phase flipped
	tap_t           target_tap;           // Edge plus offset, saturated
	logic [tap_w:0] edge_sum;             // One bit wider for the carry

	assign sel_mask = group_mask_t'(1) << group_sel;

	////////////////////////////////////////////////////////////////////////////
	// Strobes and tap count
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk357 or negedge rst_n) begin
		if (!rst_n) begin
			delay_rst <= '0;
			delay_ce  <= '0;
			tap_cnt   <= '0;
			edge_tap  <= '0;
		end else begin
			delay_rst <= clear_cmd ? sel_mask : '0; // One-cycle pulse
			delay_ce  <= step_cmd ? sel_mask : '0;
			// Count moves on the same edge as the strobe
			if (clear_cmd)
				tap_cnt <= '0;
			else if (step_cmd)
				tap_cnt <= tap_cnt + tap_t'(1);
			if (mark_edge)
				edge_tap <= tap_cnt;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Target and compares
	////////////////////////////////////////////////////////////////////////////

	assign edge_sum   = {1'b0, edge_tap} + (tap_w + 1)'(offset_taps);
	assign target_tap = (edge_sum > max_tap) ? tap_t'(max_tap) : edge_sum[tap_w-1:0];

	assign at_max    = (tap_cnt == tap_t'(max_tap));
	assign at_target = (tap_cnt == target_tap);  // Valid once an edge is marked
	assign cur_tap   = tap_cnt;

	// Delay element would wrap to tap 0 on a step from the last tap
	a_no_wrap: assert property (@(posedge clk357) disable iff (!rst_n)
		step_cmd |-> (tap_cnt != tap_t'(max_tap)));

endmodule

/* hw/cal_sequencer.sv */
`timescale 1ns/1ps

module cal_sequencer (
	input  logic              clk357,
	input  logic              rst_n,
	input  logic              cal_valid,
	input  font5_pkg::group_t cal_group,
	input  logic              res_ready,
	input  logic              timer_done,   // End of settle wait
	input  logic              phase_flip,   // Data-ready phase moved off tap 0
	input  logic              at_max,       // Delay on its last tap
	input  logic              at_target,    // Delay on edge plus offset
	output logic              cal_ready,
	output logic              res_valid,
	output logic              res_no_edge,
	output font5_pkg::group_t group_sel,
	output logic              timer_start,
	output logic              capture_ref,
	output logic              sample_en,
	output logic              clear_cmd,
	output logic              step_cmd,
	output logic              mark_edge
);
	import font5_pkg::*;

	cal_state_t state;
	cal_state_t state_nxt;
	group_t     group_q;                  // Latched request group
	logic       no_edge_q;                // Search ran off the end
	logic       accept;                   // Request handshake

	assign accept      = cal_valid && cal_ready;
	assign cal_ready   = (state == idle);
	assign res_valid   = (state == report);
	assign res_no_edge = no_edge_q;
	assign group_sel   = group_q;

	////////////////////////////////////////////////////////////////////////////
	// State and result registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk357 or negedge rst_n) begin
		if (!rst_n) begin
			state     <= idle;
			group_q   <= '0;
			no_edge_q <= 1'b0;
		end else begin
			state <= state_nxt;
			if (accept) begin
				group_q   <= cal_group;
				no_edge_q <= 1'b0;     // Fresh result per request
			end
			if (state == clear_fail)
				no_edge_q <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Next state and command decode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		state_nxt   = state;
		timer_start = 1'b0;
		capture_ref = 1'b0;
		sample_en   = 1'b0;
		clear_cmd   = 1'b0;
		step_cmd    = 1'b0;
		mark_edge   = 1'b0;
		case (state)
			idle: begin
				if (cal_valid)
					state_nxt = clear;
			end
			clear: begin
				clear_cmd   = 1'b1;       // Delay to tap 0
				timer_start = 1'b1;
				state_nxt   = settle_ref;
			end
			settle_ref: begin
				if (timer_done) begin
					capture_ref = 1'b1;   // Tap-0 phase is the reference
					state_nxt   = step;
				end
			end
			step: begin
				step_cmd    = 1'b1;
				timer_start = 1'b1;
				state_nxt   = settle_step;
			end
			settle_step: begin
				if (timer_done) begin
					sample_en = 1'b1;
					if (phase_flip) begin
						mark_edge = 1'b1; // This tap is the edge
						state_nxt = trim;
					end else if (at_max) begin
						state_nxt = clear_fail;
					end else begin
						state_nxt = step;
					end
				end
			end
			trim: begin
				// Target already saturated, so no step past the last tap
				if (at_target) begin
					state_nxt = report;
				end else begin
					step_cmd    = 1'b1;
					timer_start = 1'b1;
					state_nxt   = settle_trim;
				end
			end
			settle_trim: begin
				if (timer_done)
					state_nxt = trim;
			end
			clear_fail: begin
				clear_cmd = 1'b1;         // Park at tap 0, reported as 0
				state_nxt = report;
			end
			report: begin
				if (res_ready)
					state_nxt = idle;     // Held here under back-pressure
			end
			default: state_nxt = idle;
		endcase
	end

	// Only groups 0 to 2 exist behind the delay strobes
	a_group_legal: assert property (@(posedge clk357) disable iff (!rst_n)
		accept |-> (cal_group < n_groups));

	// Result stays up and unchanged until it is taken
	a_res_hold: assert property (@(posedge clk357) disable iff (!rst_n)
		(res_valid && !res_ready) |=> (res_valid && $stable(res_no_edge)));

endmodule

/* hw/font5_delay_cal_top.sv */
`timescale 1ns/1ps

module font5_delay_cal_top (
	input  logic                   clk357,
	input  logic                   rst_n,
	// Calibration request
	input  logic                   cal_valid,
	input  font5_pkg::group_t      cal_group,
	output logic                   cal_ready,
	// Calibration result
	output logic                   res_valid,
	output font5_pkg::tap_t        res_tap,
	output logic                   res_no_edge,
	input  logic                   res_ready,
	// Strobes to the group clock delays
	output font5_pkg::group_mask_t delay_rst,
	output font5_pkg::group_mask_t delay_ce,
	// DDR samples of each group's data-ready line
	input  font5_pkg::group_mask_t q1,
	input  font5_pkg::group_mask_t q2
);
	import font5_pkg::*;

	group_t group_sel;                    // Group under calibration
	tap_t   cur_tap;                      // Tap the selected delay sits at
	logic   timer_start;
	logic   timer_done;
	logic   capture_ref;
	logic   sample_en;
	logic   phase_flip;
	logic   clear_cmd;
	logic   step_cmd;
	logic   mark_edge;
	logic   at_max;
	logic   at_target;

	// Tap count stays put in report, so the result holds by itself
	assign res_tap = cur_tap;

	cal_sequencer cal_sequencer_inst (
		.clk357      (clk357),
		.rst_n       (rst_n),
		.cal_valid   (cal_valid),
		.cal_group   (cal_group),
		.res_ready   (res_ready),
		.timer_done  (timer_done),
		.phase_flip  (phase_flip),
		.at_max      (at_max),
		.at_target   (at_target),
		.cal_ready   (cal_ready),
		.res_valid   (res_valid),
		.res_no_edge (res_no_edge),
		.group_sel   (group_sel),
		.timer_start (timer_start),
		.capture_ref (capture_ref),
		.sample_en   (sample_en),
		.clear_cmd   (clear_cmd),
		.step_cmd    (step_cmd),
		.mark_edge   (mark_edge)
	);

	settle_timer settle_timer_inst (
		.clk357      (clk357),
		.rst_n       (rst_n),
		.timer_start (timer_start),
		.timer_done  (timer_done)
	);

	phase_monitor phase_monitor_inst (
		.clk357      (clk357),
		.rst_n       (rst_n),
		.q1          (q1),
		.q2          (q2),
		.group_sel   (group_sel),
		.capture_ref (capture_ref),
		.sample_en   (sample_en),
		.phase_flip  (phase_flip)
	);

	delay_tap_ctrl delay_tap_ctrl_inst (
		.clk357    (clk357),
		.rst_n     (rst_n),
		.group_sel (group_sel),
		.clear_cmd (clear_cmd),
		.step_cmd  (step_cmd),
		.mark_edge (mark_edge),
		.delay_rst (delay_rst),
		.delay_ce  (delay_ce),
		.cur_tap   (cur_tap),
		.at_max    (at_max),
		.at_target (at_target)
	);

endmodule

/* sim/tb_font5_delay_cal.sv */
`timescale 1ns/1ps

module tb_font5_delay_cal;
	import font5_pkg::*;

	localparam int clk_half    = 10;      // 20 ns period
	localparam int rst_cycles  = 8;
	localparam int seed        = 67951;
	localparam int edge_offset = 8;       // Taps past the edge
	localparam int last_tap    = 63;
	localparam int n_random    = 20;
	// 28 calibrations, worst case 64 taps of about 18 cycles each
	localparam int timeout_cycles = 40000;

	logic        clk357;
	logic        rst_n;
	logic        cal_valid;
	group_t      cal_group;
	logic        cal_ready;
	logic        res_valid;
	tap_t        res_tap;
	logic        res_no_edge;
	logic        res_ready;
	group_mask_t delay_rst;
	group_mask_t delay_ce;
	group_mask_t q1 = '0;
	group_mask_t q2 = '1;

	int model_tap [n_groups];             // Delay element tap per group
	int edge_pos  [n_groups] = '{default: 0}; // Hidden data-ready edge

	string test_name;
	int    test_group;
	int    test_errs;
	logic  test_done;
	int    n_tests;
	int    n_pass;
	int    n_fail;
	int    err_total;
	int    cycle_cnt = 0;

	// Checker state
	logic  model_pending;                 // Model tap check on next edge
	logic  bp_hold;                       // Result held back last cycle
	tap_t  held_tap;
	logic  held_no_edge;

	font5_delay_cal_top font5_delay_cal_top_inst (
		.clk357      (clk357),
		.rst_n       (rst_n),
		.cal_valid   (cal_valid),
		.cal_group   (cal_group),
		.cal_ready   (cal_ready),
		.res_valid   (res_valid),
		.res_tap     (res_tap),
		.res_no_edge (res_no_edge),
		.res_ready   (res_ready),
		.delay_rst   (delay_rst),
		.delay_ce    (delay_ce),
		.q1          (q1),
		.q2          (q2)
	);

	initial begin
		clk357 = 1'b0;
		forever #clk_half clk357 = ~clk357;
	end

	always @(posedge clk357) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= timeout_cycles) begin
			$display("Timeout: calibration stalled, no verdict after %0d cycles", cycle_cnt);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Delay line model
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk357 or negedge rst_n) begin : delay_model
		int nxt;
		if (!rst_n) begin
			for (int g = 0; g < n_groups; g++)
				model_tap[g] <= 0;
		end else begin
			for (int g = 0; g < n_groups; g++) begin
				if (delay_rst[g])
					nxt = 0;                 // Clear wins over a step
				else if (delay_ce[g])
					nxt = model_tap[g] + 1;
				else
					nxt = model_tap[g];
				model_tap[g] <= nxt;
				q1[g] <= (nxt < edge_pos[g]);  // High below the edge
				q2[g] <= !(nxt < edge_pos[g]); // Falling sample, inverse
			end
		end
	end

	// {no_edge, tap} for a hidden edge position
	function automatic logic [tap_w:0] expected_result(input int e);
		logic [tap_w:0] r;
		if (e >= 1 && e <= last_tap) begin
			if (e + edge_offset > last_tap)
				r = {1'b0, tap_t'(last_tap)};      // Saturated
			else
				r = {1'b0, tap_t'(e + edge_offset)};
		end else begin
			r = {1'b1, tap_t'(0)};                 // No flip anywhere
		end
		return r;
	endfunction

	task automatic report_mismatch(input string what, input int exp, input int act);
		$display("[FAIL] %s %s: expected %0d, actual %0d", test_name, what, exp, act);
		test_errs = test_errs + 1;
		err_total = err_total + 1;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Result checker, sampled mid-cycle
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk357) begin : result_check
		logic [tap_w:0] exp;
		group_mask_t    others;
		exp    = expected_result(edge_pos[test_group]);
		others = ~(group_mask_t'(1) << test_group);
		if (rst_n) begin
			// Strobes may only hit the group under calibration
			if (((delay_rst | delay_ce) & others) != '0) begin
				$display("%s: delay strobe on a group other than %0d (rst %b, ce %b)",
					test_name, test_group, delay_rst, delay_ce);
				test_errs = test_errs + 1;
				err_total = err_total + 1;
			end
			if (bp_hold) begin
				if (res_valid !== 1'b1)
					report_mismatch("res_valid under back-pressure", 1, res_valid);
				if (res_tap !== held_tap)
					report_mismatch("res_tap under back-pressure", held_tap, res_tap);
				if (res_no_edge !== held_no_edge)
					report_mismatch("res_no_edge under back-pressure", held_no_edge,
						res_no_edge);
			end
			if (res_valid && cal_ready !== 1'b0)
				report_mismatch("cal_ready while result pending", 0, cal_ready);
			bp_hold      = res_valid && !res_ready;
			held_tap     = res_tap;
			held_no_edge = res_no_edge;

			// Model has seen the last strobe one edge after the handshake
			if (model_pending) begin
				model_pending = 1'b0;
				if (model_tap[test_group] != int'(exp[tap_w-1:0]))
					report_mismatch("delay model tap", exp[tap_w-1:0],
						model_tap[test_group]);
				n_tests = n_tests + 1;
				if (test_errs == 0) begin
					$display("%-14s ok      group %0d edge %0d tap %0d no_edge %0d",
						test_name, test_group, edge_pos[test_group],
						exp[tap_w-1:0], exp[tap_w]);
					n_pass = n_pass + 1;
				end else begin
					$display("%-14s failed  %0d errors", test_name, test_errs);
					n_fail = n_fail + 1;
				end
				test_done = 1'b1;
			end
			if (res_valid && res_ready) begin   // Taken on the next edge
				if (res_tap !== exp[tap_w-1:0])
					report_mismatch("res_tap", exp[tap_w-1:0], res_tap);
				if (res_no_edge !== exp[tap_w])
					report_mismatch("res_no_edge", exp[tap_w], res_no_edge);
				model_pending = 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	task automatic run_cal(input string name, input int group, input int e,
		input int hold);
		@(posedge clk357);
		test_name  = name;
		test_group = group;
		test_errs  = 0;
		test_done  = 1'b0;
		edge_pos[group] <= e;
		cal_valid <= 1'b1;
		cal_group <= group_t'(group);
		do begin
			@(negedge clk357);
		end while (!cal_ready);
		@(posedge clk357);                  // Request taken here
		cal_valid <= 1'b0;
		do begin
			@(negedge clk357);
		end while (!res_valid);
		repeat (hold) @(negedge clk357);    // Back-pressure
		@(posedge clk357);
		res_ready <= 1'b1;
		do begin
			@(negedge clk357);
		end while (!(res_valid && res_ready));
		@(posedge clk357);
		res_ready <= 1'b0;
		wait (test_done);
	endtask

	task automatic check_reset_state();
		@(negedge clk357);
		test_name = "reset_state";
		test_errs = 0;
		if (cal_ready !== 1'b1)
			report_mismatch("cal_ready", 1, cal_ready);
		if (res_valid !== 1'b0)
			report_mismatch("res_valid", 0, res_valid);
		if (delay_rst !== '0)
			report_mismatch("delay_rst", 0, delay_rst);
		if (delay_ce !== '0)
			report_mismatch("delay_ce", 0, delay_ce);
		n_tests = n_tests + 1;
		if (test_errs == 0) begin
			$display("%-14s ok", test_name);
			n_pass = n_pass + 1;
		end else begin
			$display("%-14s failed  %0d errors", test_name, test_errs);
			n_fail = n_fail + 1;
		end
	endtask

	initial begin
		int grp;
		int e;
		int hold;
		void'($urandom(seed));
		rst_n     <= 1'b0;
		cal_valid <= 1'b0;
		cal_group <= '0;
		res_ready <= 1'b0;
		test_name     = "reset";
		test_group    = 0;
		test_errs     = 0;
		test_done     = 1'b0;
		n_tests       = 0;
		n_pass        = 0;
		n_fail        = 0;
		err_total     = 0;
		model_pending = 1'b0;
		bp_hold       = 1'b0;
		held_tap      = '0;
		held_no_edge  = 1'b0;
		repeat (rst_cycles) @(posedge clk357);
		rst_n <= 1'b1;
		check_reset_state();

		run_cal("basic_g0", 0, 20, 0);
		run_cal("basic_g1", 1, 20, 0);
		run_cal("basic_g2", 2, 20, 0);
		run_cal("saturate_e60", 1, 60, 0);
		run_cal("saturate_e63", 2, 63, 0);
		run_cal("no_edge_e0", 0, 0, 0);
		run_cal("no_edge_e70", 2, 70, 0);
		run_cal("backpressure", 1, 35, $urandom_range(3, 12));

		for (int i = 0; i < n_random; i++) begin
			grp  = $urandom_range(0, n_groups - 1);
			e    = $urandom_range(0, 70);
			hold = $urandom_range(0, 3);
			run_cal($sformatf("random_%02d", i), grp, e, hold);
		end

		repeat (2) @(posedge clk357);
		$display("Tests %0d, passed %0d, failed %0d, check errors %0d",
			n_tests, n_pass, n_fail, err_total);
		if (err_total == 0 && n_fail == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* font5_delay_cal_top.f */
hw/font5_pkg.sv
hw/settle_timer.sv
hw/phase_monitor.sv
hw/delay_tap_ctrl.sv
hw/cal_sequencer.sv
hw/font5_delay_cal_top.sv
sim/tb_font5_delay_cal.sv

/* Makefile */
TOP   := tb_font5_delay_cal
FLIST := font5_delay_cal_top.f

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f $(FLIST)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "TEST RESULT: PASS" sim.log; then \
		echo "Simulation ended without a verdict"; \
		exit 1; \
	fi

lint:
	verilator --lint-only -Wall --top-module font5_delay_cal_top \
		hw/font5_pkg.sv hw/settle_timer.sv hw/phase_monitor.sv \
		hw/delay_tap_ctrl.sv hw/cal_sequencer.sv hw/font5_delay_cal_top.sv

clean:
	rm -rf obj_dir sim.log
